// ==== Bender.yml ====
package:
  name: nes_bus

sources:
  # RTL in compile order
  - files:
      - hdl/nes_bus_pkg.sv
      - hdl/bus_if.sv
      - hdl/clock_enable_gen.sv
      - hdl/dma_controller.sv
      - hdl/bus_decoder.sv
      - hdl/nes_bus_top.sv

  # Testbench top tb_nes_bus
  - target: test
    files:
      - verification/tb_nes_bus.sv

// ==== hdl/bus_decoder.sv ====
// Address decode, joypad strobe and clocks, open-bus byte and CPU read data for the merged bus
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
	input  wire                            clk,
	input  wire                            reset,
	bus_if.decoder                         bus,
	input  wire  [4:0]                     joypad1_data,
	input  wire  [4:0]                     joypad2_data,
	input  wire  [nes_bus_pkg::data_w-1:0] ext_din,       // Cart and memory data
	output logic [nes_bus_pkg::data_w-1:0] rdata,         // Byte returned to CPU and DMA
	output logic [2:0]                     joypad_out,    // Strobe bits to the joypads
	output logic [1:0]                     joypad_clock,  // Shift pulse per joypad
	output logic                           ppu_cs
);
	import nes_bus_pkg::*;

	logic              apu_cs;      // 0x4000 to 0x4017
	logic              joy1_cs;
	logic              joy2_cs;
	logic [data_w-1:0] open_bus;    // Last value seen on the data bus
	logic [2:0]        joy_strobe;

	// Range decode on the full word
	assign ppu_cs  = (bus.addr.word >= ppu_base) && (bus.addr.word < apu_base);
	assign apu_cs  = (bus.addr.word >= apu_base) && (bus.addr.word < apu_end);
	assign joy1_cs = (bus.addr.word == joy1_addr);
	assign joy2_cs = (bus.addr.word == joy2_addr);

	// Strobe bits from a write to 0x4016
	always_ff @(posedge clk) begin
		if (reset)
			joy_strobe <= 3'b000;
		else if (joy1_cs && bus.wr)
			joy_strobe <= bus.wdata[2:0];
	end

	assign joypad_out = joy_strobe;

	// Each read of a joypad port shifts that pad once
	assign joypad_clock = {joy2_cs && bus.rd, joy1_cs && bus.rd};

	// Returned byte
	always_comb begin
		if (reset)
			rdata = '0;
		else if (joy1_cs)
			rdata = {open_bus[7:5], joypad1_data};  // Upper bits float on the pad port
		else if (joy2_cs)
			rdata = {open_bus[7:5], joypad2_data};
		else if (apu_cs)
			rdata = open_bus;  // No APU here, bus keeps its old value
		else
			rdata = ext_din;
	end

	// Bus capacitance, follows the returned byte
	always_ff @(posedge clk) begin
		open_bus <= rdata;
	end

endmodule

`default_nettype wire

// ==== hdl/bus_if.sv ====
// Merged CPU/DMA bus carried from the top-level mux into the address decoder
`timescale 1ns/1ps
`default_nettype none

interface bus_if;
	import nes_bus_pkg::*;

	bus_addr_t         addr;   // Address after the DMA mux
	logic [data_w-1:0] wdata;  // Write data, CPU or sprite latch
	logic              rd;     // Read cycle
	logic              wr;     // Write cycle

	// Mux side
	modport driver (
		output addr,
		output wdata,
		output rd,
		output wr
	);

	// Decoder side
	modport decoder (
		input addr,
		input wdata,
		input rd,
		input wr
	);

endinterface

`default_nettype wire

// ==== hdl/clock_enable_gen.sv ====
// Divides the master clock into CPU, PPU and cart enables, with PAL stretch and held reset
`timescale 1ns/1ps
`default_nettype none

module clock_enable_gen #(
	parameter int cpu_div = nes_bus_pkg::cpu_div_default,  // Master clocks per CPU cycle
	parameter int ppu_div = nes_bus_pkg::ppu_div_default   // Master clocks per PPU dot
) (
	input  wire  clk,
	input  wire  reset,
	input  wire  pal,        // 1 = PAL timing
	output logic cpu_ce,
	output logic ppu_ce,
	output logic cart_ce,
	output logic odd_cycle,  // Toggles every CPU cycle
	output logic sys_reset   // Reset stretched to the first CPU enable
);

	// CPU counter runs 1..cpu_div, the stretched cycle holds it instead of counting on
	localparam int cnt_w  = $clog2(cpu_div + 1);
	localparam int pcnt_w = $clog2(ppu_div + 1);
	// Room for one extra tick in the PAL cycle
	localparam int tick_w = $clog2(cpu_div / ppu_div + 2);
	localparam int pal_period = 5;  // One long CPU cycle in five

	localparam logic [cnt_w-1:0]  cpu_last = cnt_w'(cpu_div);
	localparam logic [pcnt_w-1:0] ppu_last = pcnt_w'(ppu_div);

	logic [cnt_w-1:0]  div_cpu;         // Counts 1..cpu_div
	logic [pcnt_w-1:0] div_ppu;         // Counts 1..ppu_div
	logic [tick_w-1:0] ppu_tick;        // PPU enables since the last CPU enable
	logic [2:0]        cpu_tick_count;  // Position in the PAL group of five
	logic              last_pal;        // For realign on a system change
	logic              hold_reset;
	logic              stretch_cycle;   // This CPU cycle gets the extra PPU tick
	logic              skip_cpu_count;

	assign cpu_ce  = (div_cpu == cpu_last);
	assign ppu_ce  = (div_ppu == ppu_last);

	assign stretch_cycle  = (cpu_tick_count == 3'(pal_period - 1));
	assign skip_cpu_count = stretch_cycle && (ppu_tick == '0);  // Hold CPU during first dot

	// Cart runs on the first dot where the CPU address is on the bus
	assign cart_ce = ppu_ce && (ppu_tick == (stretch_cycle ? tick_w'(1) : tick_w'(0)));

	assign sys_reset = reset || hold_reset;

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cpu        <= cnt_w'(1);
			div_ppu        <= pcnt_w'(1);
			ppu_tick       <= '0;
			cpu_tick_count <= '0;
			last_pal       <= pal;
		end else if (pal != last_pal) begin
			// System type changed, start both dividers together
			last_pal       <= pal;
			div_cpu        <= cnt_w'(1);
			div_ppu        <= pcnt_w'(1);
			ppu_tick       <= '0;
			cpu_tick_count <= '0;
		end else begin
			if (!skip_cpu_count) begin
				if (cpu_ce)
					div_cpu <= cnt_w'(1);
				else
					div_cpu <= div_cpu + 1'b1;
			end

			div_ppu <= ppu_ce ? pcnt_w'(1) : div_ppu + 1'b1;

			if (cpu_ce)
				ppu_tick <= '0;  // Tick 0 is the first dot of the cycle
			else if (ppu_ce)
				ppu_tick <= ppu_tick + 1'b1;

			if (cpu_ce && pal)
				cpu_tick_count <= stretch_cycle ? 3'd0 : cpu_tick_count + 3'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			hold_reset <= 1'b1;
		else if (cpu_ce)
			hold_reset <= 1'b0;  // Released on the first CPU enable
	end

	// Even/odd flag starts even once the core leaves reset
	always_ff @(posedge clk) begin
		if (sys_reset)
			odd_cycle <= 1'b0;
		else if (cpu_ce)
			odd_cycle <= !odd_cycle;
	end

endmodule

`default_nettype wire

// ==== hdl/dma_controller.sv ====
// Sprite and DMC DMA engine that pauses the CPU and takes over the bus on CPU enables
`timescale 1ns/1ps
`default_nettype none

module dma_controller (
	input  wire                             clk,
	input  wire                             reset,
	input  wire                             ce,            // CPU enable
	input  wire                             odd_cycle,
	input  wire                             sprite_start,  // Write to 0x4014 seen
	input  wire  [nes_bus_pkg::data_w-1:0]  page,          // Source page from the CPU
	input  wire                             cpu_rnw,       // CPU in a read cycle
	input  wire  [nes_bus_pkg::data_w-1:0]  rdata,         // Data returned on the bus
	input  wire                             dmc_req,       // Held until dmc_ack
	input  nes_bus_pkg::bus_addr_t          dmc_addr,
	output nes_bus_pkg::bus_addr_t          dma_addr,
	output logic [nes_bus_pkg::data_w-1:0]  dma_wdata,
	output logic                            dma_own,       // DMA drives the bus
	output logic                            dma_rd,        // 1 = read, 0 = write
	output logic                            dmc_ack,
	output logic                            pause_cpu
);
	import nes_bus_pkg::*;

	logic              dmc_state;    // DMC fetch due on the next even enable
	logic [1:0]        spr_state;    // Bit 0 pending, bit 1 active
	bus_addr_t         src_addr;     // Sprite source pointer
	logic [data_w-1:0] spr_latch;    // Byte read on the even slot
	logic [data_w:0]   next_offset;  // Carry out marks the last pair

	assign next_offset = {1'b0, src_addr.paged.offset} + 1'b1;

	always_ff @(posedge clk) begin
		if (reset) begin
			dmc_state <= 1'b0;
			spr_state <= 2'b00;
		end else if (ce) begin
			// DMC only starts from an even CPU read cycle
			if (!dmc_state && dmc_req && cpu_rnw && !odd_cycle)
				dmc_state <= 1'b1;
			else if (dmc_state && !odd_cycle)
				dmc_state <= 1'b0;  // Fetch done this enable

			if (sprite_start)
				spr_state <= 2'b01;  // Pause, wait for an odd read cycle
			else if (spr_state == 2'b01 && cpu_rnw && odd_cycle)
				spr_state <= 2'b11;  // Take the bus, next slot is a read
			else if (spr_state[1] && !odd_cycle && dmc_state)
				spr_state <= 2'b01;  // DMC stole the read slot, retry the pair
			else if (spr_state[1] && odd_cycle && next_offset[data_w])
				spr_state <= 2'b00;  // 256th write done
		end
	end

	always_ff @(posedge clk) begin
		if (ce) begin
			if (sprite_start) begin
				src_addr.paged.page   <= page;
				src_addr.paged.offset <= '0;
			end else if (spr_state[1] && odd_cycle) begin
				src_addr.paged.offset <= next_offset[data_w-1:0];  // Step after each write
			end

			if (spr_state[1] && !odd_cycle)
				spr_latch <= rdata;
		end
	end

	// Even slots read, odd slots write to the OAM port
	always_comb begin
		if (dmc_ack)
			dma_addr = dmc_addr;
		else if (!odd_cycle)
			dma_addr = src_addr;
		else
			dma_addr.word = oam_data_addr;
	end

	assign dmc_ack   = dmc_state && !odd_cycle;
	assign dma_own   = dmc_ack || spr_state[1];
	assign dma_rd    = !odd_cycle;
	assign dma_wdata = spr_latch;
	assign pause_cpu = spr_state[0] || dmc_req;  // CPU holds while anything is due

endmodule

`default_nettype wire

// ==== hdl/nes_bus_pkg.sv ====
// Shared widths, register addresses, divider defaults and the address type used by the bus core
`default_nettype none

package nes_bus_pkg;

	// Bus widths
	localparam int addr_w = 16;                 // CPU address bus
	localparam int data_w = 8;                  // CPU data bus

	// Divider defaults, master clocks per enable
	localparam int cpu_div_default = 12;        // NTSC CPU cycle
	localparam int ppu_div_default = 4;         // NTSC PPU dot

	// Register addresses
	localparam logic [addr_w-1:0] oam_data_addr   = 16'h2004;  // Sprite memory data port
	localparam logic [addr_w-1:0] sprite_dma_addr = 16'h4014;  // Write starts sprite DMA
	localparam logic [addr_w-1:0] joy1_addr       = 16'h4016;  // Joypad 1, strobe on write
	localparam logic [addr_w-1:0] joy2_addr       = 16'h4017;  // Joypad 2

	// Chip select bounds, end is exclusive
	localparam logic [addr_w-1:0] ppu_base = 16'h2000;
	localparam logic [addr_w-1:0] apu_base = 16'h4000;  // Also top of the PPU mirror range
	localparam logic [addr_w-1:0] apu_end  = 16'h4018;

	// Page and offset halves of an address
	// Page selects the 256-byte block, offset walks through it
	typedef struct packed {
		logic [data_w-1:0] page;    // High byte
		logic [data_w-1:0] offset;  // Low byte, stepped by sprite DMA
	} bus_page_t;

	// One address word, two views
	// word for range compares in the decoder
	// paged for the DMA source pointer
	typedef union packed {
		logic [addr_w-1:0] word;
		bus_page_t         paged;
	} bus_addr_t;

endpackage

`default_nettype wire

// ==== hdl/nes_bus_top.sv ====
// Console bus core top level joining clock enables, DMA, bus mux and decoder on plain ports
`timescale 1ns/1ps
`default_nettype none

module nes_bus_top #(
	parameter int cpu_div = nes_bus_pkg::cpu_div_default,
	parameter int ppu_div = nes_bus_pkg::ppu_div_default
) (
	input  wire                            clk,
	input  wire                            reset,
	input  wire                            pal,
	input  wire  [nes_bus_pkg::addr_w-1:0] cpu_addr,
	input  wire                            cpu_rnw,
	input  wire  [nes_bus_pkg::data_w-1:0] cpu_dout,
	input  wire                            dmc_req,
	input  wire  [nes_bus_pkg::addr_w-1:0] dmc_addr,
	input  wire  [4:0]                     joypad1_data,
	input  wire  [4:0]                     joypad2_data,
	input  wire  [nes_bus_pkg::data_w-1:0] ext_din,
	output logic                           cpu_ce,
	output logic                           ppu_ce,
	output logic                           cart_ce,
	output logic [nes_bus_pkg::data_w-1:0] cpu_din,
	output logic                           pause_cpu,
	output logic                           dmc_ack,
	output logic [nes_bus_pkg::addr_w-1:0] bus_addr,
	output logic [nes_bus_pkg::data_w-1:0] bus_dout,
	output logic                           bus_rd,
	output logic                           bus_wr,
	output logic                           ppu_cs,
	output logic [2:0]                     joypad_out,
	output logic [1:0]                     joypad_clock
);
	import nes_bus_pkg::*;

	logic              sys_reset;     // Held until the first CPU enable
	logic              odd_cycle;
	logic              sprite_start;
	bus_addr_t         dma_addr;
	logic [data_w-1:0] dma_wdata;
	logic              dma_own;
	logic              dma_rd;
	logic [data_w-1:0] rdata;

	bus_if bus ();

	clock_enable_gen #(
		.cpu_div (cpu_div),
		.ppu_div (ppu_div)
	) u_clock_enable_gen (
		.clk       (clk),
		.reset     (reset),
		.pal       (pal),
		.cpu_ce    (cpu_ce),
		.ppu_ce    (ppu_ce),
		.cart_ce   (cart_ce),
		.odd_cycle (odd_cycle),
		.sys_reset (sys_reset)
	);

	// Bus mux, DMA wins while it owns the bus
	assign bus.addr  = dma_own ? dma_addr : bus_addr_t'(cpu_addr);
	assign bus.wdata = dma_own ? dma_wdata : cpu_dout;
	assign bus.rd    = !sys_reset && (dma_own ? dma_rd : cpu_rnw);   // Idle in reset
	assign bus.wr    = !sys_reset && (dma_own ? !dma_rd : !cpu_rnw);

	// Sprite DMA trigger on the merged bus
	assign sprite_start = bus.wr && (bus.addr.word == sprite_dma_addr);

	dma_controller u_dma_controller (
		.clk          (clk),
		.reset        (sys_reset),
		.ce           (cpu_ce),
		.odd_cycle    (odd_cycle),
		.sprite_start (sprite_start),
		.page         (cpu_dout),               // Written value is the page
		.cpu_rnw      (cpu_rnw),
		.rdata        (rdata),
		.dmc_req      (dmc_req),
		.dmc_addr     (bus_addr_t'(dmc_addr)),
		.dma_addr     (dma_addr),
		.dma_wdata    (dma_wdata),
		.dma_own      (dma_own),
		.dma_rd       (dma_rd),
		.dmc_ack      (dmc_ack),
		.pause_cpu    (pause_cpu)
	);

	bus_decoder u_bus_decoder (
		.clk          (clk),
		.reset        (sys_reset),
		.bus          (bus),
		.joypad1_data (joypad1_data),
		.joypad2_data (joypad2_data),
		.ext_din      (ext_din),
		.rdata        (rdata),
		.joypad_out   (joypad_out),
		.joypad_clock (joypad_clock),
		.ppu_cs       (ppu_cs)
	);

	assign cpu_din  = rdata;         // Same byte feeds CPU and DMA latch
	assign bus_addr = bus.addr.word;
	assign bus_dout = bus.wdata;
	assign bus_rd   = bus.rd;
	assign bus_wr   = bus.wr;

endmodule

`default_nettype wire

// ==== verification/tb_nes_bus.sv ====
// Testbench for the bus core top level, runs enable, PAL, DMA and joypad tests with assertions
`timescale 1ns/1ps
`default_nettype none

module tb_nes_bus;
	import nes_bus_pkg::*;

	// Two sprite transfers of about 520 CPU cycles each plus short tests, with margin
	localparam int timeout_clocks = 4000 * cpu_div_default;
	localparam logic [7:0]  dma_page  = 8'h03;    // Sprite source page
	localparam logic [15:0] dmc_src   = 16'hc123; // DMC sample address
	localparam logic [15:0] idle_addr = 16'h8000;

	logic clk = 1'b0;
	logic reset;
	logic pal;
	logic [15:0] cpu_addr;
	logic cpu_rnw;
	logic [7:0] cpu_dout;
	logic dmc_req;
	logic [15:0] dmc_addr;
	logic [4:0] joypad1_data;
	logic [4:0] joypad2_data;
	logic [7:0] ext_din;
	logic cpu_ce, ppu_ce, cart_ce, pause_cpu, dmc_ack, bus_rd, bus_wr, ppu_cs;
	logic [7:0] cpu_din;
	logic [7:0] bus_dout;
	logic [15:0] bus_addr;
	logic [2:0] joypad_out;
	logic [1:0] joypad_clock;

	int cycle = 0;     // Master clocks since time 0
	int errors = 0;
	int test_err0;     // Error count at the start of the current test
	int tests_run = 0;
	int tests_failed = 0;
	string test_name;
	int ce_count = 0;  // CPU enables since reset release
	bit spr_watch = 0; // Sprite monitor armed
	bit want_write;    // Read seen, its OAM write still due
	bit check_release = 0;
	int spr_reads, spr_writes, dmc_acks;
	logic [7:0] exp_data;

	nes_bus_top #(.cpu_div(cpu_div_default), .ppu_div(ppu_div_default)) dut (.*);

	always #50 clk = ~clk;  // 100 ns master clock

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= timeout_clocks) begin
			$display("Timeout after %0d clocks, a test never finished", cycle);
			$display("** FAIL **");
			$finish;
		end
	end

	always @(negedge clk) ext_din <= bus_addr[7:0];  // Memory returns the low address byte

	task report_mismatch(input string name, input int exp, input int act);
		$display("Error: %s expected %0h actual %0h", name, exp, act);
		errors++;
	endtask

	task report_fault(input string msg);
		$display("Failure in %s: %s", test_name, msg);
		errors++;
	endtask

	// Slot parity, the first enable ends the held reset without a toggle
	function automatic bit enable_is_odd(input int n);
		return (n != 1) && (n % 2 == 1);
	endfunction

	cart_in_ppu: assert property (@(posedge clk) cart_ce |-> ppu_ce)
		else report_fault("cart_ce without ppu_ce");
	dmc_fetch: assert property (@(posedge clk) disable iff (reset)
		(cpu_ce && dmc_ack) |-> (bus_rd && bus_addr == dmc_src))
		else report_mismatch("dmc_steal", dmc_src, bus_addr);

	// Bus monitor, sampled mid-cycle ahead of each enable edge
	always @(negedge clk) begin
		if (check_release) begin
			check_release = 0;
			assert (!pause_cpu) else report_fault("pause_cpu still high after the last write");
		end
		if (!reset && cpu_ce) begin
			ce_count++;
			if (dmc_ack) begin
				dmc_acks++;
				assert (!enable_is_odd(ce_count)) else report_fault("dmc_ack on an odd enable");
			end
			if (spr_watch && bus_rd && bus_addr[15:8] == dma_page) begin
				assert (!want_write) else report_fault("sprite read before the previous write");
				assert (bus_addr[7:0] == spr_reads[7:0])
					else report_mismatch(test_name, {dma_page, spr_reads[7:0]}, bus_addr);
				assert (pause_cpu) else report_fault("pause_cpu low during sprite read");
				exp_data = bus_addr[7:0];  // Memory model byte for this address
				want_write = 1;
				spr_reads++;
			end
			if (spr_watch && bus_wr && bus_addr == oam_data_addr) begin
				assert (want_write) else report_fault("OAM write without a sprite read");
				assert (bus_dout == exp_data) else report_mismatch(test_name, exp_data, bus_dout);
				assert (pause_cpu) else report_fault("pause_cpu low during OAM write");
				assert (ppu_cs) else report_fault("ppu_cs low on the OAM write");
				want_write = 0;
				spr_writes++;
				if (spr_writes == 256)
					check_release = 1;  // pause_cpu must fall after this enable
			end
		end
	end

	task wait_enable();
		do @(negedge clk); while (!cpu_ce);
	endtask

	// One CPU bus cycle, started just after an enable and held off while paused
	task cpu_access(input logic [15:0] addr, input logic rnw, input logic [7:0] data,
			output logic [7:0] rdata);
		wait_enable();
		@(negedge clk);
		cpu_addr = addr;
		cpu_rnw  = rnw;
		cpu_dout = data;
		do @(negedge clk); while (!cpu_ce || pause_cpu);
		rdata = cpu_din;
		@(negedge clk);
		cpu_rnw = 1'b1;  // Idle as a read of the same address
	endtask

	task start_test(input string name);
		test_name = name;
		test_err0 = errors;
		spr_reads = 0;
		spr_writes = 0;
		dmc_acks = 0;
		want_write = 0;
	endtask

	task end_test();
		tests_run++;
		if (errors == test_err0) begin
			$display("Test %s passed", test_name);
		end else begin
			$display("Test %s failed with %0d errors", test_name, errors - test_err0);
			tests_failed++;
		end
	endtask

	task check_ntsc_enables();
		int last_cpu;
		int last_ppu;
		int n_cpu;
		last_cpu = -1;
		last_ppu = -1;
		n_cpu = 0;
		start_test("ntsc_enables");
		@(negedge clk);  // Still inside the held reset
		assert (!pause_cpu && !dmc_ack) else report_fault("pause_cpu or dmc_ack high after reset");
		assert (!bus_rd && !bus_wr) else report_fault("bus strobe active in reset");
		repeat (64) begin
			@(negedge clk);
			if (cpu_ce) begin
				if (last_cpu >= 0)
					assert (cycle - last_cpu == 12) else report_mismatch(test_name, 12, cycle - last_cpu);
				last_cpu = cycle;
				n_cpu++;
			end
			if (ppu_ce) begin
				if (last_ppu >= 0)
					assert (cycle - last_ppu == 4) else report_mismatch(test_name, 4, cycle - last_ppu);
				last_ppu = cycle;
			end
		end
		assert (n_cpu >= 4) else report_fault("too few CPU enables");
		end_test();
	endtask

	task check_pal_stretch();
		int iv[10];
		int last;
		int sum;
		int longs;
		start_test("pal_stretch");
		@(negedge clk);
		pal = 1'b1;
		repeat (3) wait_enable();  // Past the realign period
		last = cycle;
		for (int i = 0; i < 10; i++) begin
			wait_enable();
			iv[i] = cycle - last;
			last = cycle;
		end
		for (int w = 0; w <= 5; w++) begin
			sum = 0;
			longs = 0;
			for (int k = 0; k < 5; k++) begin
				sum += iv[w + k];
				if (iv[w + k] == 16)
					longs++;
			end
			assert (sum == 64) else report_mismatch(test_name, 64, sum);
			assert (longs == 1) else report_mismatch(test_name, 1, longs);
		end
		pal = 1'b0;
		repeat (2) wait_enable();  // Back to NTSC spacing
		end_test();
	endtask

	task check_sprite_dma(input string name, input bit steal);
		logic [7:0] rd;
		start_test(name);
		spr_watch = 1;
		fork
			begin
				cpu_access(sprite_dma_addr, 1'b0, dma_page, rd);
				assert (pause_cpu) else report_fault("pause_cpu did not rise after 0x4014 write");
				cpu_access(idle_addr, 1'b1, 8'h00, rd);  // Completes once the DMA lets go
			end
			if (steal) begin
				repeat (40) wait_enable();
				dmc_req = 1'b1;
				do @(negedge clk); while (!dmc_ack);
				dmc_req = 1'b0;  // Request dropped once acknowledged
			end
		join
		spr_watch = 0;
		assert (spr_reads == 256) else report_mismatch(test_name, 256, spr_reads);
		assert (spr_writes == 256) else report_mismatch(test_name, 256, spr_writes);
		assert (dmc_acks == (steal ? 1 : 0)) else report_mismatch(test_name, steal, dmc_acks);
		assert (!pause_cpu) else report_fault("pause_cpu high after the transfer");
		end_test();
	endtask

	task check_joypads();
		logic [7:0] rd;
		logic [7:0] expect_byte;
		start_test("joypad_open_bus");
		@(negedge clk);
		joypad1_data = 5'($urandom);
		joypad2_data = 5'($urandom);
		cpu_access(joy1_addr, 1'b0, 8'h05, rd);
		assert (joypad_out == 3'b101) else report_mismatch(test_name, 3'b101, joypad_out);
		cpu_access(16'h00c3, 1'b1, 8'h00, rd);
		assert (rd == 8'hc3) else report_mismatch(test_name, 8'hc3, rd);
		cpu_access(joy1_addr, 1'b1, 8'h00, rd);
		expect_byte = {3'b110, joypad1_data};  // Upper bits from the 0xc3 byte
		assert (rd == expect_byte) else report_mismatch(test_name, expect_byte, rd);
		assert (joypad_clock == 2'b01) else report_mismatch(test_name, 2'b01, joypad_clock);
		cpu_access(joy2_addr, 1'b1, 8'h00, rd);
		expect_byte = {3'b110, joypad2_data};
		assert (rd == expect_byte) else report_mismatch(test_name, expect_byte, rd);
		assert (joypad_clock == 2'b10) else report_mismatch(test_name, 2'b10, joypad_clock);
		cpu_access(16'h4005, 1'b1, 8'h00, rd);
		assert (rd == expect_byte) else report_mismatch(test_name, expect_byte, rd);
		assert (joypad_clock == 2'b00) else report_mismatch(test_name, 2'b00, joypad_clock);
		assert (!ppu_cs) else report_fault("ppu_cs high outside the PPU range");
		end_test();
	endtask

	initial begin
		void'($urandom(32'h87f2));
		reset = 1'b1;
		pal = 1'b0;
		cpu_addr = idle_addr;
		cpu_rnw = 1'b1;
		cpu_dout = 8'h00;
		dmc_req = 1'b0;
		dmc_addr = dmc_src;
		joypad1_data = 5'h00;
		joypad2_data = 5'h00;
		ext_din = 8'h00;
		repeat (2) @(negedge clk);
		reset = 1'b0;
		check_ntsc_enables();
		check_pal_stretch();
		check_sprite_dma("sprite_dma", 1'b0);
		check_sprite_dma("dmc_steal", 1'b1);
		check_joypads();
		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
hdl/nes_bus_pkg.sv
hdl/bus_if.sv
hdl/clock_enable_gen.sv
hdl/dma_controller.sv
hdl/bus_decoder.sv
hdl/nes_bus_top.sv
verification/tb_nes_bus.sv
